/* vlog.f */
src/rtc_edit_pkg.sv
src/button_pulse.sv
src/field_edit_ctrl.sv
src/commit_sequencer.sv
src/rtc_register_mirror.sv
src/rtc_edit_top.sv
testbench/rtc_edit_asserts.sv
testbench/tb_rtc_edit.sv

/* Makefile */
# Verilator build and run of the RTC edit testbench

VERILATOR ?= verilator
TOP       ?= tb_rtc_edit
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= TESTBENCH PASSED
VFLAGS    ?= --binary --assert -Wno-fatal --top-module $(TOP)

.PHONY: sim clean

# build, run, and decide by the pass line in the log
sim:
	$(VERILATOR) $(VFLAGS) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* testbench/tb_rtc_edit.sv */
`timescale 1ns/1ns

module tb_rtc_edit;

	import rtc_edit_pkg::*;

	logic       CLK;
	logic       reset;
	logic       btn_left, btn_right, btn_up, btn_down, btn_save;
	group_t     group_sel;
	field_idx_t view_field;
	field_idx_t cursor;
	logic       edit_active, wr_strobe, commit_done;
	logic [7:0] wr_addr, wr_data, view_value;

	// model of cursor, counters and clock chip contents
	int         m_cursor;
	group_t     m_group;
	logic [7:0] m_up [13];
	logic [7:0] m_down [13];
	logic [7:0] m_mirror [13];
	logic [7:0] addr_q [$];
	logic [7:0] data_q [$];
	int         done_seen;
	integer     seed;
	int         err_cursor, err_active, err_bus, err_mirror, err_timeout;

	rtc_edit_top #(.DATA_W(8)) dut
	(
		.CLK(CLK), .reset(reset),
		.btn_left(btn_left), .btn_right(btn_right), .btn_up(btn_up),
		.btn_down(btn_down), .btn_save(btn_save),
		.group_sel(group_sel), .view_field(view_field), .cursor(cursor),
		.edit_active(edit_active), .wr_strobe(wr_strobe), .wr_addr(wr_addr),
		.wr_data(wr_data), .commit_done(commit_done), .view_value(view_value)
	);

	bind commit_sequencer rtc_edit_asserts u_asserts
	(
		.CLK(CLK), .reset(reset), .fw_strobe(fw_strobe), .wr_strobe(wr_strobe),
		.wr_addr(wr_addr), .field_ack(field_ack), .grant(grant),
		.commit_done(commit_done)
	);

	initial
	begin
		CLK = 1'b0;
		forever #10 CLK = ~CLK;
	end

	////////////////////////////////////////////////////////////////////////////
	// field map as seen from the panel
	////////////////////////////////////////////////////////////////////////////

	function automatic int first_of(input group_t g);
		case (g)
			GRP_ALARM: return 6;
			GRP_TIMER: return 10;
			default:   return 0;
		endcase
	endfunction

	function automatic int last_of(input group_t g);
		case (g)
			GRP_CLOCK: return 5;
			GRP_ALARM: return 9;
			default:   return 12;
		endcase
	endfunction

	// each group counts up from its own base address
	function automatic logic [7:0] expected_addr(input int f);
		if (f < 6)
			return 8'h21 + 8'(f);
		else if (f < 10)
			return 8'h41 + 8'(f - 6);
		else
			return 8'hF1 + 8'(f - 10);
	endfunction

	// bus and commit_done capture
	always @(negedge CLK)
	begin
		if (!reset && wr_strobe)
		begin
			addr_q.push_back(wr_addr);
			data_q.push_back(wr_data);
		end
		if (!reset && commit_done)
			done_seen++;
	end

	////////////////////////////////////////////////////////////////////////////
	// stimulus and model updates
	////////////////////////////////////////////////////////////////////////////

	task automatic press(input int kind);
		@(negedge CLK);
		case (kind)
			0:       btn_left = 1'b1;
			1:       btn_right = 1'b1;
			2:       btn_up = 1'b1;
			3:       btn_down = 1'b1;
			default: btn_save = 1'b1;
		endcase
		repeat (5) @(negedge CLK);
		btn_left  = 1'b0;
		btn_right = 1'b0;
		btn_up    = 1'b0;
		btn_down  = 1'b0;
		btn_save  = 1'b0;
		repeat (4) @(negedge CLK);
	endtask

	task automatic model_press(input int kind);
		if (m_group != GRP_IDLE)
		begin
			if (kind == 0 && m_cursor != first_of(m_group))
				m_cursor--;
			else if (kind == 1 && m_cursor != last_of(m_group))
				m_cursor++;
			else if (kind == 2)
				m_up[m_cursor]++;
			else if (kind == 3)
				m_down[m_cursor]++;
		end
	endtask

	task automatic check_cursor(input string name);
		if (cursor !== field_idx_t'(m_cursor))
		begin
			$display("Error: %s cursor expected %0d actual %0d", name, m_cursor, cursor);
			err_cursor++;
		end
	endtask

	task automatic set_group(input group_t g);
		@(negedge CLK);
		group_sel = g;
		m_group   = g;
		// cursor outside the new group jumps to its first field
		if (g != GRP_IDLE && (m_cursor < first_of(g) || m_cursor > last_of(g)))
			m_cursor = first_of(g);
		repeat (3) @(negedge CLK);
		check_cursor("group change");
		// editing is on for every group but idle
		if (edit_active !== (g != GRP_IDLE))
		begin
			$display("Error: group change edit_active expected %0b actual %0b",
				g != GRP_IDLE, edit_active);
			err_active++;
		end
	endtask

	task automatic pick_active_group();
		int unsigned r;
		r = $random(seed);
		set_group(group_t'(1 + r % 3));
	endtask

	task automatic random_edits(input int n);
		int unsigned r;
		for (int i = 0; i < n; i++)
		begin
			r = $random(seed);
			if (r % 6 >= 4)
				set_group(group_t'($random(seed) & 3));
			else
			begin
				press(r % 6);
				model_press(r % 6);
				check_cursor("button press");
			end
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// commit and readback
	////////////////////////////////////////////////////////////////////////////

	task automatic run_commit(input int abort_at, input int busy, input string name);
		int          n;
		int          waited;
		int          expect_n;
		int unsigned r;
		logic [7:0]  exp;
		addr_q.delete();
		data_q.delete();
		done_seen = 0;
		n         = 0;
		waited    = 0;
		@(negedge CLK);
		btn_save = 1'b1;
		if (abort_at > 0)
		begin
			// drop to idle right after the chosen write
			while (n < abort_at && waited < 200)
			begin
				@(negedge CLK);
				waited++;
				if (wr_strobe)
					n++;
			end
			group_sel = GRP_IDLE;
			m_group   = GRP_IDLE;
			btn_save  = 1'b0;
			repeat (30) @(negedge CLK);
			expect_n = abort_at;
			if (done_seen != 0)
			begin
				$display("%s still pulsed commit_done after the abort", name);
				err_bus++;
			end
		end
		else
		begin
			repeat (5) @(negedge CLK);
			btn_save = 1'b0;
			repeat (5) @(negedge CLK);
			// these land while grant is high and must be ignored
			for (int i = 0; i < busy; i++)
			begin
				r = $random(seed);
				press(r % 4);
			end
			while (done_seen == 0 && waited < 200)
			begin
				@(negedge CLK);
				waited++;
			end
			expect_n = 13;
		end
		if (waited >= 200)
		begin
			$display("timeout while waiting for the bus writes of %s", name);
			err_timeout++;
		end
		if (addr_q.size() != expect_n)
		begin
			$display("Error: %s bus write count expected %0d actual %0d",
				name, expect_n, addr_q.size());
			err_bus++;
		end
		for (int f = 0; f < expect_n && f < addr_q.size(); f++)
		begin
			exp = m_mirror[f] + m_up[f] - m_down[f];
			if (addr_q[f] !== expected_addr(f))
			begin
				$display("Error: %s field %0d address expected %h actual %h",
					name, f, expected_addr(f), addr_q[f]);
				err_bus++;
			end
			if (data_q[f] !== exp)
			begin
				$display("Error: %s field %0d data expected %h actual %h", name, f, exp, data_q[f]);
				err_bus++;
			end
			m_mirror[f] = exp;
			m_up[f]     = 8'h00;
			m_down[f]   = 8'h00;
		end
	endtask

	task automatic check_mirror(input string name);
		for (int f = 0; f < 13; f++)
		begin
			@(negedge CLK);
			view_field = field_idx_t'(f);
			@(negedge CLK);
			if (view_value !== m_mirror[f])
			begin
				$display("Error: %s field %0d view expected %h actual %h",
					name, f, m_mirror[f], view_value);
				err_mirror++;
			end
		end
	endtask

	initial
	begin
		int unsigned r;
		int          assert_fails;
		seed        = 32'hb001;
		reset       = 1'b1;
		btn_left    = 1'b0;
		btn_right   = 1'b0;
		btn_up      = 1'b0;
		btn_down    = 1'b0;
		btn_save    = 1'b0;
		group_sel   = GRP_IDLE;
		view_field  = '0;
		m_cursor    = 0;
		m_group     = GRP_IDLE;
		done_seen   = 0;
		err_cursor  = 0;
		err_active  = 0;
		err_bus     = 0;
		err_mirror  = 0;
		err_timeout = 0;
		for (int f = 0; f < 13; f++)
		begin
			m_up[f]     = 8'h00;
			m_down[f]   = 8'h00;
			m_mirror[f] = 8'h00;
		end
		repeat (3) @(negedge CLK);
		reset = 1'b0;

		set_group(GRP_CLOCK);
		random_edits(40);
		pick_active_group();
		run_commit(0, 2, "first commit");
		check_cursor("presses during commit");
		check_mirror("first commit");
		// counters were cleared, values come back unchanged
		run_commit(0, 0, "repeat commit");
		check_mirror("repeat commit");

		random_edits(40);
		pick_active_group();
		r = $random(seed);
		run_commit(1 + r % 12, 0, "aborted commit");
		check_cursor("aborted commit");
		check_mirror("aborted commit");
		pick_active_group();
		run_commit(0, 0, "resumed commit");
		check_mirror("resumed commit");

		assert_fails = dut.u_seq.u_asserts.fail_cnt;
		$display("error counts: cursor %0d, active %0d, bus %0d, mirror %0d, timeout %0d, assert %0d",
			err_cursor, err_active, err_bus, err_mirror, err_timeout, assert_fails);
		if (err_cursor + err_active + err_bus + err_mirror + err_timeout + assert_fails == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

/* testbench/rtc_edit_asserts.sv */
`timescale 1ns/1ns

module rtc_edit_asserts
(
	input logic       CLK,
	input logic       reset,
	input logic       fw_strobe,
	input logic       wr_strobe,
	input logic [7:0] wr_addr,
	input logic       field_ack,
	input logic       grant,
	input logic       commit_done
);

	import rtc_edit_pkg::*;

	// number of failed assertions
	int unsigned fail_cnt;

	initial
	begin
		fail_cnt = 0;
	end

	// true when the address is one of the clock chip field registers
	function automatic logic known_addr(input logic [7:0] addr);
		logic found;
		found = 1'b0;
		for (int i = 0; i < NUM_FIELDS; i++)
		begin
			if (addr == FIELD_ADDR[i])
				found = 1'b1;
		end
		return found;
	endfunction

	strobe_single: assert property (@(posedge CLK) disable iff (reset)
		wr_strobe |=> !wr_strobe)
		else
		begin
			$error("wr_strobe stayed high for more than one cycle");
			fail_cnt++;
		end

	addr_known: assert property (@(posedge CLK) disable iff (reset)
		wr_strobe |-> known_addr(wr_addr))
		else
		begin
			$error("bus write to an address outside the field map");
			fail_cnt++;
		end

	// every field write comes back as a bus write and its ack together
	ack_with_write: assert property (@(posedge CLK) disable iff (reset)
		fw_strobe |=> (field_ack && wr_strobe))
		else
		begin
			$error("field write not followed by field_ack with wr_strobe");
			fail_cnt++;
		end

	// next field write no earlier than three cycles on
	strobe_spacing: assert property (@(posedge CLK) disable iff (reset)
		fw_strobe |-> (!$past(fw_strobe) && !$past(fw_strobe, 2)))
		else
		begin
			$error("field writes issued closer than three cycles apart");
			fail_cnt++;
		end

	done_in_grant: assert property (@(posedge CLK) disable iff (reset)
		commit_done |-> grant)
		else
		begin
			$error("commit_done pulsed while grant was low");
			fail_cnt++;
		end

endmodule

/* src/rtc_edit_top.sv */
`timescale 1ns/1ns

module rtc_edit_top
#(
	parameter int DATA_W = 8
)
(
	input  logic                      CLK,
	input  logic                      reset,
	input  logic                      btn_left,
	input  logic                      btn_right,
	input  logic                      btn_up,
	input  logic                      btn_down,
	input  logic                      btn_save,
	input  rtc_edit_pkg::group_t      group_sel,
	input  rtc_edit_pkg::field_idx_t  view_field,
	output rtc_edit_pkg::field_idx_t  cursor,
	output logic                      edit_active,
	output logic                      wr_strobe,
	output logic [7:0]                wr_addr,
	output logic [DATA_W-1:0]         wr_data,
	output logic                      commit_done,
	output logic [DATA_W-1:0]         view_value
);

	logic left_p, right_p, up_p, down_p, save_p;
	logic grant, field_ack, fw_strobe, mem_we;
	logic [7:0] fw_addr;
	logic [DATA_W-1:0] fw_data, mem_data, cur_value;
	rtc_edit_pkg::field_idx_t field_ptr, fw_field;

	button_pulse u_buttons
	(
		.CLK(CLK), .reset(reset),
		.btn_left(btn_left), .btn_right(btn_right), .btn_up(btn_up),
		.btn_down(btn_down), .btn_save(btn_save),
		.left_p(left_p), .right_p(right_p), .up_p(up_p), .down_p(down_p), .save_p(save_p)
	);

	field_edit_ctrl #(.DATA_W(DATA_W)) u_edit
	(
		.CLK(CLK), .reset(reset), .group_sel(group_sel),
		.left_p(left_p), .right_p(right_p), .up_p(up_p), .down_p(down_p),
		.grant(grant), .cur_value(cur_value), .field_ack(field_ack),
		.edit_active(edit_active), .cursor(cursor), .field_ptr(field_ptr),
		.fw_strobe(fw_strobe), .fw_field(fw_field), .fw_addr(fw_addr),
		.fw_data(fw_data), .commit_done(commit_done)
	);

	// mirror is written by address, the slot index stays inside the sequencer
	commit_sequencer #(.DATA_W(DATA_W)) u_seq
	(
		.CLK(CLK), .reset(reset), .save_p(save_p), .edit_active(edit_active),
		.fw_strobe(fw_strobe), .fw_field(fw_field), .fw_addr(fw_addr),
		.fw_data(fw_data), .commit_done(commit_done), .grant(grant),
		.mem_we(mem_we), .mem_field(), .mem_data(mem_data),
		.wr_strobe(wr_strobe), .wr_addr(wr_addr), .wr_data(wr_data),
		.field_ack(field_ack)
	);

	rtc_register_mirror #(.DATA_W(DATA_W)) u_mirror
	(
		.CLK(CLK), .reset(reset), .mem_we(mem_we), .mem_addr(wr_addr),
		.mem_data(mem_data), .rd_field_a(field_ptr), .rd_field_b(view_field),
		.rd_data_a(cur_value), .rd_data_b(view_value)
	);

endmodule

/* src/rtc_register_mirror.sv */
`timescale 1ns/1ns

module rtc_register_mirror
#(
	parameter int DATA_W = 8
)
(
	input  logic                      CLK,
	input  logic                      reset,
	input  logic                      mem_we,
	input  logic [7:0]                mem_addr,
	input  logic [DATA_W-1:0]         mem_data,
	input  rtc_edit_pkg::field_idx_t  rd_field_a,
	input  rtc_edit_pkg::field_idx_t  rd_field_b,
	output logic [DATA_W-1:0]         rd_data_a,
	output logic [DATA_W-1:0]         rd_data_b
);

	import rtc_edit_pkg::*;

	logic [DATA_W-1:0] slots [NUM_FIELDS];
	field_idx_t        slot_sel;
	logic              hit;

	// address to slot lookup
	always_comb
	begin
		hit      = 1'b0;
		slot_sel = '0;
		for (int i = 0; i < NUM_FIELDS; i++)
		begin
			if (mem_addr == FIELD_ADDR[i])
			begin
				hit      = 1'b1;
				slot_sel = field_idx_t'(i);
			end
		end
	end

	always_ff @(posedge CLK)
	begin
		if (reset)
		begin
			for (int i = 0; i < NUM_FIELDS; i++)
				slots[i] <= '0;
		end
		else if (mem_we && hit)
			slots[slot_sel] <= mem_data;
	end

	// unused indices 13..15 read as zero
	assign rd_data_a = (rd_field_a < field_idx_t'(NUM_FIELDS)) ? slots[rd_field_a] : '0;
	assign rd_data_b = (rd_field_b < field_idx_t'(NUM_FIELDS)) ? slots[rd_field_b] : '0;

endmodule

/* src/commit_sequencer.sv */
`timescale 1ns/1ns

module commit_sequencer
#(
	parameter int DATA_W = 8
)
(
	input  logic                      CLK,
	input  logic                      reset,
	input  logic                      save_p,
	input  logic                      edit_active,
	input  logic                      fw_strobe,
	input  rtc_edit_pkg::field_idx_t  fw_field,
	input  logic [7:0]                fw_addr,
	input  logic [DATA_W-1:0]         fw_data,
	input  logic                      commit_done,
	output logic                      grant,
	output logic                      mem_we,
	output rtc_edit_pkg::field_idx_t  mem_field,
	output logic [DATA_W-1:0]         mem_data,
	output logic                      wr_strobe,
	output logic [7:0]                wr_addr,
	output logic [DATA_W-1:0]         wr_data,
	output logic                      field_ack
);

	logic accept;

	// strobes after an abort are dropped, counters stay with the editor
	assign accept = fw_strobe && grant;

	always_ff @(posedge CLK)
	begin
		if (reset)
		begin
			grant     <= 1'b0;
			mem_we    <= 1'b0;
			wr_strobe <= 1'b0;
			field_ack <= 1'b0;
		end
		else
		begin
			if (!edit_active)
				grant <= 1'b0;
			else if (commit_done)
				grant <= 1'b0;
			else if (save_p && !grant)
				grant <= 1'b1;

			// bus, mirror and ack in the same cycle
			wr_strobe <= accept;
			mem_we    <= accept;
			field_ack <= accept;
		end
	end

	always_ff @(posedge CLK)
	begin
		if (accept)
		begin
			wr_addr   <= fw_addr;
			wr_data   <= fw_data;
			mem_field <= fw_field;
			mem_data  <= fw_data;
		end
	end

endmodule

/* src/field_edit_ctrl.sv */
`timescale 1ns/1ns

module field_edit_ctrl
#(
	parameter int DATA_W = 8
)
(
	input  logic                      CLK,
	input  logic                      reset,
	input  rtc_edit_pkg::group_t      group_sel,
	input  logic                      left_p,
	input  logic                      right_p,
	input  logic                      up_p,
	input  logic                      down_p,
	input  logic                      grant,
	input  logic [DATA_W-1:0]         cur_value,
	input  logic                      field_ack,
	output logic                      edit_active,
	output rtc_edit_pkg::field_idx_t  cursor,
	output rtc_edit_pkg::field_idx_t  field_ptr,
	output logic                      fw_strobe,
	output rtc_edit_pkg::field_idx_t  fw_field,
	output logic [7:0]                fw_addr,
	output logic [DATA_W-1:0]         fw_data,
	output logic                      commit_done
);

	import rtc_edit_pkg::*;

	localparam field_idx_t LAST_FIELD = field_idx_t'(NUM_FIELDS - 1);

	logic [DATA_W-1:0] up_cnt   [NUM_FIELDS];
	logic [DATA_W-1:0] down_cnt [NUM_FIELDS];

	field_idx_t grp_first;
	field_idx_t grp_last;
	field_idx_t cursor_next;
	logic       edit_req;
	logic       waiting;
	logic       issue;

	// presses only count outside a commit
	assign edit_req = (group_sel != GRP_IDLE) && !grant;

	always_ff @(posedge CLK)
	begin
		if (reset)
			edit_active <= 1'b0;
		else
			edit_active <= (group_sel != GRP_IDLE);
	end

	////////////////////////////////////////////////////////////////////////////
	// cursor
	////////////////////////////////////////////////////////////////////////////

	always_comb
	begin
		grp_first   = GROUP_FIRST[group_sel];
		grp_last    = GROUP_LAST[group_sel];
		cursor_next = cursor;
		if (edit_req)
		begin
			if (left_p && cursor != grp_first)
				cursor_next = cursor - 1'b1;
			else if (right_p && cursor != grp_last)
				cursor_next = cursor + 1'b1;
		end
		// clamp into the selected group
		if (group_sel != GRP_IDLE && (cursor_next < grp_first || cursor_next > grp_last))
			cursor_next = grp_first;
	end

	always_ff @(posedge CLK)
	begin
		if (reset)
			cursor <= '0;
		else
			cursor <= cursor_next;
	end

	////////////////////////////////////////////////////////////////////////////
	// up and down counters per field
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLK)
	begin
		if (reset)
		begin
			for (int i = 0; i < NUM_FIELDS; i++)
			begin
				up_cnt[i]   <= '0;
				down_cnt[i] <= '0;
			end
		end
		else
		begin
			for (int i = 0; i < NUM_FIELDS; i++)
			begin
				// written field starts over from zero
				if (field_ack && fw_field == field_idx_t'(i))
				begin
					up_cnt[i]   <= '0;
					down_cnt[i] <= '0;
				end
				else if (edit_req && cursor == field_idx_t'(i))
				begin
					if (up_p)
						up_cnt[i] <= up_cnt[i] + 1'b1;
					else if (down_p)
						down_cnt[i] <= down_cnt[i] + 1'b1;
				end
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// commit walk
	////////////////////////////////////////////////////////////////////////////

	// no new write in the commit_done cycle, grant is still high there
	assign issue = grant && edit_active && !waiting && !commit_done;

	always_ff @(posedge CLK)
	begin
		if (reset)
		begin
			field_ptr   <= '0;
			waiting     <= 1'b0;
			fw_strobe   <= 1'b0;
			commit_done <= 1'b0;
		end
		else
		begin
			fw_strobe   <= 1'b0;
			commit_done <= 1'b0;
			if (!grant)
			begin
				// idle or aborted, restart at field 0 next time
				field_ptr <= '0;
				waiting   <= 1'b0;
			end
			else if (waiting)
			begin
				if (field_ack)
				begin
					waiting <= 1'b0;
					if (field_ptr == LAST_FIELD)
					begin
						field_ptr   <= '0;
						commit_done <= 1'b1;
					end
					else
						field_ptr <= field_ptr + 1'b1;
				end
			end
			else if (issue)
			begin
				fw_strobe <= 1'b1;
				waiting   <= 1'b1;
			end
		end
	end

	// write payload, new value wraps modulo 2^DATA_W
	always_ff @(posedge CLK)
	begin
		if (issue)
		begin
			fw_field <= field_ptr;
			fw_addr  <= FIELD_ADDR[field_ptr];
			fw_data  <= cur_value + up_cnt[field_ptr] - down_cnt[field_ptr];
		end
	end

endmodule

/* src/button_pulse.sv */
`timescale 1ns/1ns

module button_pulse
(
	input  logic CLK,
	input  logic reset,
	input  logic btn_left,
	input  logic btn_right,
	input  logic btn_up,
	input  logic btn_down,
	input  logic btn_save,
	output logic left_p,
	output logic right_p,
	output logic up_p,
	output logic down_p,
	output logic save_p
);

	logic [4:0] raw;
	logic [4:0] sync1;
	logic [4:0] sync2;
	logic [4:0] prev;
	logic [4:0] pulse_q;

	// bit order save, down, up, right, left
	assign raw = {btn_save, btn_down, btn_up, btn_right, btn_left};

	always_ff @(posedge CLK)
	begin
		if (reset)
		begin
			sync1   <= '0;
			sync2   <= '0;
			prev    <= '0;
			pulse_q <= '0;
		end
		else
		begin
			sync1   <= raw;
			sync2   <= sync1;
			prev    <= sync2;
			// one pulse per rising edge, holding gives nothing more
			pulse_q <= sync2 & ~prev;
		end
	end

	assign left_p  = pulse_q[0];
	assign right_p = pulse_q[1];
	assign up_p    = pulse_q[2];
	assign down_p  = pulse_q[3];
	assign save_p  = pulse_q[4];

endmodule

/* src/rtc_edit_pkg.sv */
package rtc_edit_pkg;

	////////////////////////////////////////////////////////////////////////////
	// field numbering
	////////////////////////////////////////////////////////////////////////////

	// clock 0..5, alarm 6..9, timer 10..12
	localparam int unsigned NUM_FIELDS = 13;

	typedef logic [3:0] field_idx_t;

	// position of the group switch, idle means no editing
	typedef enum logic [1:0]
	{
		GRP_IDLE  = 2'd0,
		GRP_CLOCK = 2'd1,
		GRP_ALARM = 2'd2,
		GRP_TIMER = 2'd3
	} group_t;

	////////////////////////////////////////////////////////////////////////////
	// group ranges and chip addresses
	////////////////////////////////////////////////////////////////////////////

	// idle entry spans every field
	localparam field_idx_t GROUP_FIRST [4] = '{4'd0, 4'd0, 4'd6, 4'd10};
	localparam field_idx_t GROUP_LAST  [4] = '{4'd12, 4'd5, 4'd9, 4'd12};

	// clock chip register address per field
	localparam logic [7:0] FIELD_ADDR [NUM_FIELDS] = '{
		8'h21, 8'h22, 8'h23, 8'h24, 8'h25, 8'h26,
		8'h41, 8'h42, 8'h43, 8'h44,
		8'hF1, 8'hF2, 8'hF3
	};

endpackage
